//--- Makefile
# Verilator flow for the vector differentiation block

VERILATOR ?= verilator
TOP       ?= tb_ntm_vector_differentiation
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/ntm_diff_ctrl_fsm.sv
//////////////////////////////////////////////////
// Control FSM of the vector differentiation block.
// Accepts one element at a time, hands it to the
// scalar unit and returns the difference with
// DATA_OUT_ENABLE, plus READY on the last element.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_diff_ctrl_fsm (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 START,
  input  wire                 DATA_IN_ENABLE,
  input  ntm_diff_pkg::data_t MODULO_IN,
  input  ntm_diff_pkg::data_t DATA_IN,
  input  wire                 last,
  output logic                READY,
  output logic                DATA_OUT_ENABLE,
  output ntm_diff_pkg::data_t DATA_OUT,
  output logic                cnt_load,
  output logic                cnt_step,
  ntm_diff_scalar_if.ctrl     sc
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_diff_pkg::ctrl_state_t state;

  logic start_accept;
  logic elem_accept;
  logic result_take;

  // Events seen by the FSM this cycle
  assign start_accept = (state == ntm_diff_pkg::STARTER_STATE) && START;
  assign elem_accept  = (state == ntm_diff_pkg::INPUT_STATE) && DATA_IN_ENABLE;
  assign result_take  = (state == ntm_diff_pkg::ENDER_STATE) && sc.op_ready;

  // Counter control, same cycle as the FSM event
  assign cnt_load = start_accept;
  assign cnt_step = result_take;

  //////////////////////////////////////////////////
  // State and control outputs
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_diff_pkg::STARTER_STATE;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      sc.op_start     <= 1'b0;
      sc.op_clear     <= 1'b0;
    end else begin
      // Pulses default low
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      sc.op_start     <= 1'b0;
      sc.op_clear     <= 1'b0;

      case (state)
        ntm_diff_pkg::STARTER_STATE: begin
          if (start_accept) begin
            // New vector, predecessor back to zero
            sc.op_clear <= 1'b1;
            state       <= ntm_diff_pkg::INPUT_STATE;
          end
        end
        ntm_diff_pkg::INPUT_STATE: begin
          if (elem_accept) begin
            sc.op_start <= 1'b1;
            state       <= ntm_diff_pkg::ENDER_STATE;
          end
        end
        ntm_diff_pkg::ENDER_STATE: begin
          if (result_take) begin
            DATA_OUT        <= sc.op_result;
            DATA_OUT_ENABLE <= 1'b1;
            // End of vector decided by the counter
            if (last) begin
              READY <= 1'b1;
              state <= ntm_diff_pkg::STARTER_STATE;
            end else begin
              state <= ntm_diff_pkg::INPUT_STATE;
            end
          end
        end
        default: state <= ntm_diff_pkg::STARTER_STATE;
      endcase
    end
  end

  // Operand capture on element accept
  always_ff @(posedge CLK) begin
    if (elem_accept) begin
      sc.op_modulo <= MODULO_IN;
      sc.op_data   <= DATA_IN;
    end
  end

endmodule

`default_nettype wire

//--- src/ntm_diff_index_counter.sv
//////////////////////////////////////////////////
// Element index counter.
// Takes the vector length at load, steps once per
// result and flags the last element.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_diff_index_counter (
  input  wire                CLK,
  input  wire                RST,
  input  wire                cnt_load,
  input  wire                cnt_step,
  input  ntm_diff_pkg::idx_t SIZE_IN,
  output logic               last
);

  // Captured length and running index
  ntm_diff_pkg::idx_t len_q;
  ntm_diff_pkg::idx_t idx_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      len_q <= ntm_diff_pkg::idx_t'(1);
      idx_q <= '0;
    end else if (cnt_load) begin
      // Empty vector still yields one element
      if (SIZE_IN == '0) begin
        len_q <= ntm_diff_pkg::idx_t'(1);
      end else begin
        len_q <= SIZE_IN;
      end
      idx_q <= '0;
    end else if (cnt_step) begin
      idx_q <= idx_q + ntm_diff_pkg::idx_t'(1);
    end
  end

  // Only end-of-vector test in the design
  assign last = (idx_q == (len_q - ntm_diff_pkg::idx_t'(1)));

endmodule

`default_nettype wire

//--- src/ntm_diff_pkg.sv
//////////////////////////////////////////////////
// Shared widths, vector types and FSM states of
// the vector differentiation block.
// Referenced by scoped name from every RTL file.
//////////////////////////////////////////////////

`default_nettype none

package ntm_diff_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Element, modulus and difference width
  localparam int DATA_W = 16;

  // Vector length and element index width
  localparam int IDX_W = 8;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One element, modulus or difference
  typedef logic [DATA_W-1:0] data_t;

  // Vector length or element position
  typedef logic [IDX_W-1:0] idx_t;

  // Controller states
  typedef enum logic [1:0] {
    STARTER_STATE = 2'd0,  // idle, waits for START
    INPUT_STATE   = 2'd1,  // waits for an element
    ENDER_STATE   = 2'd2   // waits for the scalar result
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/ntm_diff_scalar_if.sv
//////////////////////////////////////////////////
// Element operation link between the controller
// and the scalar differentiation unit.
// At most one operation in flight, ready two
// cycles after start.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface ntm_diff_scalar_if;

  // Controller to unit
  logic                op_start;
  logic                op_clear;
  ntm_diff_pkg::data_t op_modulo;
  ntm_diff_pkg::data_t op_data;

  // Unit to controller
  logic                op_ready;
  ntm_diff_pkg::data_t op_result;

  // Controller side
  modport ctrl (
    output op_start, op_clear, op_modulo, op_data,
    input  op_ready, op_result
  );

  // Scalar unit side
  modport unit (
    input  op_start, op_clear, op_modulo, op_data,
    output op_ready, op_result
  );

endinterface

`default_nettype wire

//--- src/ntm_scalar_differentiation.sv
//////////////////////////////////////////////////
// Two-stage modular backward difference.
// Stage one subtracts the previous sample, stage
// two adds the modulus back on a borrow.
// Result is ready two cycles after op_start.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_scalar_differentiation (
  input  wire             CLK,
  input  wire             RST,
  ntm_diff_scalar_if.unit sc
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Previous sample of the vector
  ntm_diff_pkg::data_t prev_q;

  // Subtraction with one extra bit for the borrow
  logic [ntm_diff_pkg::DATA_W:0] sub;

  // Stage one registers
  logic                s1_valid;
  logic                s1_wrap;
  ntm_diff_pkg::data_t s1_diff;
  ntm_diff_pkg::data_t s1_mod;

  assign sub = {1'b0, sc.op_data} - {1'b0, prev_q};

  //////////////////////////////////////////////////
  // Stage one
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prev_q   <= '0;
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= sc.op_start;
      if (sc.op_clear) begin
        prev_q <= '0;
      end else if (sc.op_start) begin
        // Current element becomes next predecessor
        prev_q <= sc.op_data;
      end
    end
  end

  // Raw difference, borrow and modulus
  always_ff @(posedge CLK) begin
    if (sc.op_start) begin
      s1_diff <= sub[ntm_diff_pkg::DATA_W-1:0];
      s1_wrap <= sub[ntm_diff_pkg::DATA_W];
      s1_mod  <= sc.op_modulo;
    end
  end

  //////////////////////////////////////////////////
  // Stage two
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sc.op_ready <= 1'b0;
    end else begin
      sc.op_ready <= s1_valid;
    end
  end

  // Fold negative difference back into range
  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      sc.op_result <= s1_wrap ? (s1_diff + s1_mod) : s1_diff;
    end
  end

endmodule

`default_nettype wire

//--- src/ntm_vector_differentiation.sv
//////////////////////////////////////////////////
// Vector differentiation top level.
// START opens a vector of SIZE_IN elements, each
// element returns its modular backward difference
// three cycles after DATA_IN_ENABLE.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_differentiation (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 START,
  input  wire                 DATA_IN_ENABLE,
  input  ntm_diff_pkg::idx_t  SIZE_IN,
  input  ntm_diff_pkg::data_t MODULO_IN,
  input  ntm_diff_pkg::data_t DATA_IN,
  output logic                READY,
  output logic                DATA_OUT_ENABLE,
  output ntm_diff_pkg::data_t DATA_OUT
);

  // Controller to counter
  logic cnt_load;
  logic cnt_step;
  logic last;

  // Controller to scalar unit
  ntm_diff_scalar_if sc ();

  // Element sequencing
  ntm_diff_ctrl_fsm u_ctrl (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN         (DATA_IN),
    .last            (last),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .cnt_load        (cnt_load),
    .cnt_step        (cnt_step),
    .sc              (sc.ctrl)
  );

  // Length and position
  ntm_diff_index_counter u_cnt (
    .CLK      (CLK),
    .RST      (RST),
    .cnt_load (cnt_load),
    .cnt_step (cnt_step),
    .SIZE_IN  (SIZE_IN),
    .last     (last)
  );

  // Arithmetic
  ntm_scalar_differentiation u_scalar (
    .CLK (CLK),
    .RST (RST),
    .sc  (sc.unit)
  );

endmodule

`default_nettype wire

//--- testbench/clk_rst_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset source.
// 8 ns clock, reset held for the first 8 cycles.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module clk_rst_gen (
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD = 4;
  localparam int RST_CYCLES  = 8;

  // Free running clock
  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // Reset released on a rising edge
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/ntm_vector_differentiation_props.sv
//////////////////////////////////////////////////
// Output protocol properties of the vector
// differentiation top level, attached by bind.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_differentiation_props (
  input wire                 CLK,
  input wire                 RST,
  input wire                 DATA_IN_ENABLE,
  input wire                 READY,
  input wire                 DATA_OUT_ENABLE,
  input ntm_diff_pkg::data_t DATA_OUT
);

  // READY only comes with the last result
  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else $error("READY seen without DATA_OUT_ENABLE");

  // One cycle per result
  single_cycle_result: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else $error("DATA_OUT_ENABLE held for two cycles");

  // Quiet outputs while in reset
  quiet_in_reset: assert property (@(posedge CLK)
    RST |-> (!READY && !DATA_OUT_ENABLE && (DATA_OUT == '0)))
    else $error("Output active during reset");

  // Element sampled at edge k, result registered at k+3, seen at k+4
  result_latency: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> $past(DATA_IN_ENABLE, 4))
    else $error("DATA_OUT_ENABLE without element three cycles before");

endmodule

`default_nettype wire

//--- testbench/tb_ntm_vector_differentiation.sv
//////////////////////////////////////////////////
// Testbench of the vector differentiation block.
// Replays golden vectors from a data file, then
// seeded random vectors, and checks each result.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ntm_vector_differentiation;

  localparam int WAIT_LIMIT = 20;
  localparam int MAX_ELEMS  = 16;

  logic CLK;
  logic RST;
  logic START;
  logic DATA_IN_ENABLE;
  ntm_diff_pkg::idx_t  SIZE_IN;
  ntm_diff_pkg::data_t MODULO_IN;
  ntm_diff_pkg::data_t DATA_IN;
  logic READY;
  logic DATA_OUT_ENABLE;
  ntm_diff_pkg::data_t DATA_OUT;

  // Current vector and its expected differences
  ntm_diff_pkg::data_t vec_mod  [MAX_ELEMS];
  ntm_diff_pkg::data_t vec_data [MAX_ELEMS];
  ntm_diff_pkg::data_t vec_exp  [MAX_ELEMS];

  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int out_count = 0;
  int expected_outputs = 0;
  integer seed = 32'h3fb32f8d;

  clk_rst_gen u_clk_rst (.CLK(CLK), .RST(RST));

  ntm_vector_differentiation DUT (
    .CLK(CLK), .RST(RST), .START(START), .DATA_IN_ENABLE(DATA_IN_ENABLE),
    .SIZE_IN(SIZE_IN), .MODULO_IN(MODULO_IN), .DATA_IN(DATA_IN),
    .READY(READY), .DATA_OUT_ENABLE(DATA_OUT_ENABLE), .DATA_OUT(DATA_OUT)
  );

  bind ntm_vector_differentiation ntm_vector_differentiation_props u_props (
    .CLK(CLK), .RST(RST), .DATA_IN_ENABLE(DATA_IN_ENABLE), .READY(READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE), .DATA_OUT(DATA_OUT)
  );

  // Result pulses for the closing count
  always @(posedge CLK) begin
    if (DATA_OUT_ENABLE) out_count <= out_count + 1;
  end

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    checks++;
    assert (got === expv) else begin
      $display("[ERROR] %s got %h expected %h", name, got, expv);
      errors++;
    end
  endtask

  // Element sampled by the DUT at the second edge
  // Optional stray START on the same edge
  task automatic send_element(input int idx, input bit noise);
    @(posedge CLK);
    START          <= noise;
    DATA_IN_ENABLE <= 1'b1;
    MODULO_IN      <= vec_mod[idx];
    DATA_IN        <= vec_data[idx];
    @(posedge CLK);
    START          <= 1'b0;
    DATA_IN_ENABLE <= 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // Result wait with latency counted in rising edges
  ////////////////////////////////////////////////////

  task automatic wait_result(input int idx, input int n, input bit noise);
    int lat;
    bit seen;
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < WAIT_LIMIT) begin
      @(posedge CLK);
      lat = lat + 1;
      // Stray pulses while the result is pending
      START          <= noise && (lat == 1);
      DATA_IN_ENABLE <= noise && (lat == 1);
      DATA_IN        <= ~vec_data[idx];
      @(negedge CLK);
      seen = DATA_OUT_ENABLE;
    end
    assert (seen) else begin
      $display("Timed out waiting for the result of element %0d", idx);
      timeouts++;
    end
    if (seen) begin
      compare_hex("latency", lat, 3);
      compare_hex("DATA_OUT", 32'(DATA_OUT), 32'(vec_exp[idx]));
      compare_hex("READY", 32'(READY), (idx == n - 1) ? 1 : 0);
    end
  endtask

  task automatic run_vector(input ntm_diff_pkg::idx_t size, input bit noise);
    int n;
    int i;
    n = (size == '0) ? 1 : int'(size);
    @(posedge CLK);
    START   <= 1'b1;
    SIZE_IN <= size;
    @(posedge CLK);
    START   <= 1'b0;
    // Length already captured
    SIZE_IN <= ~size;
    for (i = 0; i < n; i++) begin
      send_element(i, noise);
      wait_result(i, n, noise);
    end
    expected_outputs += n;
  endtask

  // Random vector and its expected differences
  // Predecessor of element 0 is zero
  task automatic make_random_vector(output ntm_diff_pkg::idx_t size);
    int n;
    int i;
    int mv;
    int dv;
    int pv;
    int diff;
    size = ntm_diff_pkg::idx_t'($random(seed) & 7);
    n    = (size == '0) ? 1 : int'(size);
    mv   = ($random(seed) & 32'h0000ffff) | 1;
    pv   = 0;
    for (i = 0; i < n; i++) begin
      dv   = ($random(seed) & 32'h0000ffff) % mv;
      diff = dv - pv;
      if (diff < 0) diff = diff + mv;
      vec_mod[i]  = ntm_diff_pkg::data_t'(mv);
      vec_data[i] = ntm_diff_pkg::data_t'(dv);
      vec_exp[i]  = ntm_diff_pkg::data_t'(diff);
      pv = dv;
    end
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    int fd;
    int rc;
    int guard;
    int i;
    int n;
    string line;
    ntm_diff_pkg::idx_t size;
    logic [3:0] noise_f;
    START = 1'b0;
    DATA_IN_ENABLE = 1'b0;
    SIZE_IN = '0;
    MODULO_IN = '0;
    DATA_IN = '0;
    guard = 0;
    // First edge before looking at reset
    do begin
      @(negedge CLK);
      guard++;
    end while (RST !== 1'b0 && guard < 50);
    assert (RST === 1'b0) else begin
      $display("Reset was never released");
      timeouts++;
    end
    // Idle outputs before the first START
    for (i = 0; i < 4; i++) begin
      @(negedge CLK);
      compare_hex("READY", 32'(READY), 0);
      compare_hex("DATA_OUT_ENABLE", 32'(DATA_OUT_ENABLE), 0);
      compare_hex("DATA_OUT", 32'(DATA_OUT), 0);
    end
    fd = $fopen("testbench/vector_diff_golden.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the golden vector file");
      errors++;
    end
    if (fd != 0) begin
      // Two column header lines
      rc = $fgets(line, fd);
      rc = $fgets(line, fd);
      while (!$feof(fd) && $fscanf(fd, "%h %h", size, noise_f) == 2) begin
        n = (size == '0) ? 1 : int'(size);
        for (i = 0; i < n; i++) begin
          rc = $fscanf(fd, "%h %h %h", vec_mod[i], vec_data[i], vec_exp[i]);
          assert (rc == 3) else begin
            $display("Golden record is missing element fields");
            errors++;
          end
        end
        run_vector(size, noise_f != 0);
      end
      $fclose(fd);
    end
    for (i = 0; i < 8; i++) begin
      make_random_vector(size);
      run_vector(size, ($random(seed) & 1) != 0);
    end
    repeat (4) @(negedge CLK);
    compare_hex("output count", out_count, expected_outputs);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/vector_diff_golden.txt
# size noise, then per element: modulo data expected (all hex)
# size 00 holds one element, noise 1 adds stray START and DATA_IN_ENABLE
04 0 0100 0005 0005 0100 0009 0004 0100 000c 0003 0100 0020 0014
03 0 0064 0050 0050 0070 0030 0050 0080 0010 0060
00 0 00ff 0042 0042
01 0 1000 0abc 0abc
05 1 ffff 1234 1234 ffff 0234 efff ffff f000 edcc ffff 0001 1000 ffff 0001 0000
02 1 0007 0006 0006 0005 0002 0001

//--- verilog.f
src/ntm_diff_pkg.sv
src/ntm_diff_scalar_if.sv
src/ntm_diff_ctrl_fsm.sv
src/ntm_diff_index_counter.sv
src/ntm_scalar_differentiation.sv
src/ntm_vector_differentiation.sv
testbench/clk_rst_gen.sv
testbench/ntm_vector_differentiation_props.sv
testbench/tb_ntm_vector_differentiation.sv
